// File: Makefile
# Verilator build and run for the AXI-Lite FIFO bridge testbench
TOP := tb_axil_fifo_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f verilog.f

# the run fails unless the pass line shows up in the output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: bench/bridge_cases.txt
# op: W write, R read, P push rx word, D take tx word
# op  addr_or_slot  data_hex  resp  test (0 = same test as the line above)
W 00000010 a0000001 0 1
W 00000110 b1000001 0 0
W 00000010 a0000002 0 0
W 00000110 b1000002 0 0
D 1 b1000001 0 0
D 0 a0000001 0 0
D 0 a0000002 0 0
D 1 b1000002 0 0
R 00000000 08000000 0 2
R 00000100 08000000 0 0
W 00000000 00000000 0 0
R 00000000 00000000 0 0
R 00000100 08000000 0 0
R 0000000c 00000008 0 3
W 00000010 c0000001 0 0
R 0000000c 00000007 0 0
W 00000010 c0000002 0 0
W 00000010 c0000003 0 0
W 00000010 c0000004 0 0
W 00000010 c0000005 0 0
W 00000010 c0000006 0 0
W 00000010 c0000007 0 0
W 00000010 c0000008 0 0
R 0000000c 00000000 0 0
W 00000010 c0000009 0 0
R 0000000c 00000000 0 0
D 0 c0000001 0 0
D 0 c0000002 0 0
D 0 c0000003 0 0
D 0 c0000004 0 0
D 0 c0000005 0 0
D 0 c0000006 0 0
D 0 c0000007 0 0
D 0 c0000008 0 0
R 0000000c 00000008 0 0
R 0000011c 00000000 0 4
P 1 d0000001 0 0
P 1 d0000002 0 0
P 1 d0000003 0 0
R 00000124 00000000 0 0
P 1 d0000004 0 0
P 1 d0000005 0 0
R 0000011c 00000004 0 0
R 00000124 00000010 0 0
R 00000120 d0000001 0 0
R 00000120 d0000002 0 0
R 00000120 d0000003 0 0
R 00000120 d0000004 0 0
R 00000120 d0000005 0 0
R 00000124 00000000 0 0
R 00000120 00000000 0 0
W 00000210 12345678 3 5
W 00000014 12345678 3 0
W 00010010 12345678 3 0
R 0000020c 00000000 3 0
R 00000028 00000000 3 0
R 0001000c 00000000 3 0
R 00000010 00000000 3 0
R 0000000c 00000008 0 0
R 0000010c 00000008 0 0
R 0000011c 00000000 0 0

// File: bench/tb_axil_fifo_bridge.sv
/*
 * testbench for the AXI-Lite to FIFO bridge
 * reads operations from the case file, drives the AXI-Lite and
 * stream sides of the DUT and checks responses and stream words
 */
module tb_axil_fifo_bridge
  import axil_fifo_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_MAX = 100;
  localparam int SLOT_W   = $clog2(NUM_SLOTS);
  typedef logic [SLOT_W-1:0] slot_t;

  logic                             clk_i;
  logic                             reset_i;
  axil_req_t                        req;
  axil_rsp_t                        rsp;
  logic [NUM_SLOTS-1:0]             tx_valid;
  logic [NUM_SLOTS-1:0][DATA_W-1:0] tx_data;
  logic [NUM_SLOTS-1:0]             tx_ready;
  logic [NUM_SLOTS-1:0]             rx_valid;
  logic [NUM_SLOTS-1:0][DATA_W-1:0] rx_data;
  logic [NUM_SLOTS-1:0]             rx_ready;

  int cur_test;
  int test_errs;
  int total_errs;
  int n_ok;
  int n_bad;
  bit stalled;

  axil_fifo_bridge u_axil_fifo_bridge (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .axil_req_i (req),
    .axil_rsp_o (rsp),
    .tx_valid_o (tx_valid),
    .tx_data_o  (tx_data),
    .tx_ready_i (tx_ready),
    .rx_valid_i (rx_valid),
    .rx_data_i  (rx_data),
    .rx_ready_o (rx_ready)
  );

  always #20 clk_i = ~clk_i;

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------

  // inputs change 2 ns after the rising edge
  task automatic after_edge();
    @(posedge clk_i);
    #2;
  endtask

  task automatic count_error();
    test_errs++;
    total_errs++;
  endtask

  task automatic report_stall(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, WAIT_MAX);
    stalled = 1'b1;
    count_error();
  endtask

  task automatic close_test();
    if (cur_test != 0) begin
      if (test_errs == 0) begin
        $display("test %0d done, ok", cur_test);
        n_ok++;
      end else begin
        $display("test %0d done, %0d errors", cur_test, test_errs);
        n_bad++;
      end
    end
  endtask

  // ----------------------------------------------------------
  // bus and stream tasks, sampled at the falling edge
  // ----------------------------------------------------------
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int n;
    resp = '0;
    req.awaddr  = addr;
    req.wdata   = data;
    req.wstrb   = '1;
    req.awvalid = 1'b1;
    req.wvalid  = 1'b1;
    n = 0;
    @(negedge clk_i);
    // address and data are taken in the same cycle
    while (!(rsp.awready && rsp.wready) && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (!(rsp.awready && rsp.wready)) begin
      report_stall("write address and data accept");
      return;
    end
    after_edge();
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    req.bready  = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!rsp.bvalid && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (!rsp.bvalid) begin
      report_stall("write response");
      return;
    end
    resp = rsp.bresp;
    after_edge();
    req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    data = '0;
    resp = '0;
    req.araddr  = addr;
    req.arvalid = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!rsp.arready && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (!rsp.arready) begin
      report_stall("read address accept");
      return;
    end
    after_edge();
    req.arvalid = 1'b0;
    req.rready  = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!rsp.rvalid && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (!rsp.rvalid) begin
      report_stall("read data");
      return;
    end
    data = rsp.rdata;
    resp = rsp.rresp;
    after_edge();
    req.rready = 1'b0;
  endtask

  task automatic push_rx(input slot_t slot, input logic [31:0] data);
    int n;
    rx_data[slot]  = data;
    rx_valid[slot] = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!rx_ready[slot] && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (!rx_ready[slot]) begin
      report_stall("rx stream ready");
      return;
    end
    after_edge();
    rx_valid[slot] = 1'b0;
  endtask

  task automatic take_tx(input slot_t slot, output logic [31:0] data);
    int n;
    data = '0;
    tx_ready[slot] = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!tx_valid[slot] && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (!tx_valid[slot]) begin
      report_stall("tx stream word");
      return;
    end
    data = tx_data[slot];
    after_edge();
    tx_ready[slot] = 1'b0;
  endtask

  // ----------------------------------------------------------
  // case file interpreter
  // ----------------------------------------------------------
  initial begin
    int          fd;
    int          cnt;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr_f;
    logic [31:0] data_f;
    logic [31:0] resp_f;
    int          test_f;
    logic [1:0]  got_resp;
    logic [31:0] got_data;

    clk_i    = 1'b0;
    reset_i  = 1'b1;
    req      = '0;
    tx_ready = '0;
    rx_valid = '0;
    rx_data  = '0;
    cur_test = 0;
    test_errs = 0;
    total_errs = 0;
    n_ok = 0;
    n_bad = 0;
    stalled = 1'b0;

    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    fd = $fopen("bench/bridge_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file bench/bridge_cases.txt");
      total_errs++;
    end else begin
      while (!stalled && $fgets(line, fd) != 0) begin
        if (line.len() > 4 && line[0] != "#") begin
          cnt = $sscanf(line, "%c %h %h %h %d", op, addr_f, data_f, resp_f, test_f);
          if (cnt != 5) begin
            $display("malformed line in case file: %s", line);
            count_error();
          end else begin
            // a nonzero test number opens a new test
            if (test_f != 0) begin
              close_test();
              cur_test = test_f;
              test_errs = 0;
            end
            case (op)
              "W": begin
                axil_write(addr_f, data_f, got_resp);
                if (!stalled && got_resp !== resp_f[1:0]) begin
                  $display("Fail at time %0d ns: write addr %h expected resp %0d actual %0d",
                           $time, addr_f, resp_f[1:0], got_resp);
                  count_error();
                end
              end
              "R": begin
                axil_read(addr_f, got_data, got_resp);
                if (!stalled && (got_data !== data_f || got_resp !== resp_f[1:0])) begin
                  $display("Fail at time %0d ns: read addr %h expected %h/%0d actual %h/%0d",
                           $time, addr_f, data_f, resp_f[1:0], got_data, got_resp);
                  count_error();
                end
              end
              "P": push_rx(slot_t'(addr_f), data_f);
              "D": begin
                take_tx(slot_t'(addr_f), got_data);
                if (!stalled && got_data !== data_f) begin
                  $display("Fail at time %0d ns: tx slot %0d expected %h actual %h",
                           $time, addr_f, data_f, got_data);
                  count_error();
                end
              end
              default: begin
                $display("unknown operation in case file: %s", line);
                count_error();
              end
            endcase
          end
        end
      end
      $fclose(fd);
    end

    close_test();
    $display("%0d tests ok, %0d tests with errors, %0d errors in total",
             n_ok, n_bad, total_errs);
    if (total_errs == 0 && !stalled) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: src/axil_fifo_bridge.sv
/*
 * AXI-Lite to FIFO bridge, top level
 * host writes fill per-slot tx FIFOs that drain onto streams, and
 * per-slot rx FIFOs fill from streams for host readback
 */
module axil_fifo_bridge
  import axil_fifo_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  axil_req_t                        axil_req_i,
  output axil_rsp_t                        axil_rsp_o,
  output logic [NUM_SLOTS-1:0]             tx_valid_o,
  output logic [NUM_SLOTS-1:0][DATA_W-1:0] tx_data_o,
  input  logic [NUM_SLOTS-1:0]             tx_ready_i,
  input  logic [NUM_SLOTS-1:0]             rx_valid_i,
  input  logic [NUM_SLOTS-1:0][DATA_W-1:0] rx_data_i,
  output logic [NUM_SLOTS-1:0]             rx_ready_o
);

  slot_wr_t     [NUM_SLOTS-1:0] slot_wr;
  slot_status_t [NUM_SLOTS-1:0] slot_status;
  logic         [NUM_SLOTS-1:0] rx_pop;
  logic                         awready;
  logic                         wready;
  logic [1:0]                   bresp;
  logic                         bvalid;
  logic                         arready;
  logic [DATA_W-1:0]            rdata;
  logic [1:0]                   rresp;
  logic                         rvalid;

  axil_write_decoder u_axil_write_decoder (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (axil_req_i),
    .awready_o (awready),
    .wready_o  (wready),
    .bresp_o   (bresp),
    .bvalid_o  (bvalid),
    .slot_wr_o (slot_wr)
  );

  for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
    fifo_slot u_fifo_slot (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .wr_i       (slot_wr[g]),
      .rx_pop_i   (rx_pop[g]),
      .tx_valid_o (tx_valid_o[g]),
      .tx_data_o  (tx_data_o[g]),
      .tx_ready_i (tx_ready_i[g]),
      .rx_valid_i (rx_valid_i[g]),
      .rx_data_i  (rx_data_i[g]),
      .rx_ready_o (rx_ready_o[g]),
      .status_o   (slot_status[g])
    );
  end

  axil_read_mux u_axil_read_mux (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (axil_req_i),
    .arready_o (arready),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .rvalid_o  (rvalid),
    .status_i  (slot_status),
    .rx_pop_o  (rx_pop)
  );

  // slave side of the bus
  always_comb begin
    axil_rsp_o.awready = awready;
    axil_rsp_o.wready  = wready;
    axil_rsp_o.bresp   = bresp;
    axil_rsp_o.bvalid  = bvalid;
    axil_rsp_o.arready = arready;
    axil_rsp_o.rdata   = rdata;
    axil_rsp_o.rresp   = rresp;
    axil_rsp_o.rvalid  = rvalid;
  end

endmodule

// File: src/axil_fifo_pkg.sv
/*
 * axil fifo bridge package
 * sizes, register offsets, response codes and the packed structs
 * shared between the AXI-Lite decode logic and the slot array
 */
package axil_fifo_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------
  localparam int NUM_SLOTS  = 2;
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 32;
  localparam int FIFO_DEPTH = 8;
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int SLOT_SHIFT = 8;
  localparam int SLOT_IDX_W = 8;
  localparam int UPPER_W    = ADDR_W - SLOT_IDX_W - SLOT_SHIFT;
  localparam int RLR_WORDS  = 4;
  localparam int ISR_TC_BIT = 27;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // per-slot register window offsets
  localparam logic [SLOT_SHIFT-1:0] OFS_ISR  = 8'h00;
  localparam logic [SLOT_SHIFT-1:0] OFS_TDFV = 8'h0C;
  localparam logic [SLOT_SHIFT-1:0] OFS_TDFD = 8'h10;
  localparam logic [SLOT_SHIFT-1:0] OFS_RDFO = 8'h1C;
  localparam logic [SLOT_SHIFT-1:0] OFS_RDFD = 8'h20;
  localparam logic [SLOT_SHIFT-1:0] OFS_RLR  = 8'h24;

  // ----------------------------------------------------------
  // bus and internal structs
  // ----------------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0]   awaddr;
    logic                awvalid;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                wvalid;
    logic                bready;
    logic [ADDR_W-1:0]   araddr;
    logic                arvalid;
    logic                rready;
  } axil_req_t;

  typedef struct packed {
    logic              awready;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
    logic              rvalid;
  } axil_rsp_t;

  // address as seen by the slot decode
  typedef struct packed {
    logic [UPPER_W-1:0]    upper;
    logic [SLOT_IDX_W-1:0] slot;
    logic [SLOT_SHIFT-1:0] offset;
  } reg_addr_t;

  typedef struct packed {
    logic              push;
    logic              tc_clear;
    logic [DATA_W-1:0] data;
  } slot_wr_t;

  typedef struct packed {
    logic              tc;
    logic [CNT_W-1:0]  tx_vacancy;
    logic [CNT_W-1:0]  rx_count;
    logic              rx_valid;
    logic [DATA_W-1:0] rx_head;
  } slot_status_t;

endpackage

// File: src/axil_read_mux.sv
/*
 * AXI-Lite read mux
 * decodes the read address, formats the chosen slot register and
 * registers it as the read response; RDFD reads pop the rx FIFO
 */
module axil_read_mux
  import axil_fifo_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  axil_req_t                    req_i,
  output logic                         arready_o,
  output logic [DATA_W-1:0]            rdata_o,
  output logic [1:0]                   rresp_o,
  output logic                         rvalid_o,
  input  slot_status_t [NUM_SLOTS-1:0] status_i,
  output logic [NUM_SLOTS-1:0]         rx_pop_o
);

  reg_addr_t         rd_addr;
  slot_status_t      sel;
  logic              ar_take;
  logic              slot_ok;
  logic              is_rdfd;
  logic [DATA_W-1:0] rd_data;
  logic [1:0]        rd_resp;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  logic [1:0]        rresp_q;

  assign arready_o = !rvalid_q;
  assign ar_take   = req_i.arvalid && arready_o;

  assign rd_addr = reg_addr_t'(req_i.araddr);
  assign slot_ok = (rd_addr.upper == '0) &&
                   (rd_addr.slot < SLOT_IDX_W'(NUM_SLOTS));
  assign is_rdfd = (rd_addr.offset == OFS_RDFD);

  // ----------------------------------------------------------
  // register formatting
  // ----------------------------------------------------------
  always_comb begin
    sel = '0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (rd_addr.slot == SLOT_IDX_W'(i)) sel = status_i[i];
    end

    rd_data = '0;
    rd_resp = RESP_OKAY;
    if (!slot_ok) begin
      rd_resp = RESP_DECERR;
    end else begin
      case (rd_addr.offset)
        OFS_ISR:  rd_data[ISR_TC_BIT] = sel.tc;
        OFS_TDFV: rd_data = DATA_W'(sel.tx_vacancy);
        // occupancy in whole groups of four
        OFS_RDFO: rd_data = DATA_W'({sel.rx_count[CNT_W-1:2], 2'b00});
        OFS_RLR: begin
          if (sel.rx_count >= CNT_W'(RLR_WORDS)) begin
            rd_data = DATA_W'(RLR_WORDS * (DATA_W / 8));
          end
        end
        // empty FIFO reads as zero
        OFS_RDFD: rd_data = sel.rx_valid ? sel.rx_head : '0;
        default:  rd_resp = RESP_DECERR;
      endcase
    end
  end

  // pop only the addressed slot, and only when it holds a word
  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      rx_pop_o[i] = ar_take && slot_ok && is_rdfd &&
                    (rd_addr.slot == SLOT_IDX_W'(i)) && status_i[i].rx_valid;
    end
  end

  // ----------------------------------------------------------
  // read response
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else if (ar_take) begin
      rvalid_q <= 1'b1;
    end else if (req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_take) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

  // the slot must hold a word whenever it is popped
  for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_pop_chk
    a_pop_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      rx_pop_o[g] |-> status_i[g].rx_valid);
  end

endmodule

// File: src/axil_write_decoder.sv
/*
 * AXI-Lite write decoder
 * joins the aw and w channels, decodes the slot window and issues
 * one-cycle push / tc_clear strobes, then returns the write response
 */
module axil_write_decoder
  import axil_fifo_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  axil_req_t                req_i,
  output logic                     awready_o,
  output logic                     wready_o,
  output logic [1:0]               bresp_o,
  output logic                     bvalid_o,
  output slot_wr_t [NUM_SLOTS-1:0] slot_wr_o
);

  reg_addr_t              wr_addr;
  logic                   aw_take;
  logic                   slot_ok;
  logic                   is_tdfd;
  logic                   is_isr;
  logic                   addr_ok;
  logic [NUM_SLOTS-1:0]   slot_hit;
  logic                   bvalid_q;
  logic [1:0]             bresp_q;

  // ----------------------------------------------------------
  // handshake and decode
  // ----------------------------------------------------------

  // both channels must be present, and no response may be waiting
  assign aw_take   = req_i.awvalid && req_i.wvalid && !bvalid_q;
  assign awready_o = aw_take;
  assign wready_o  = aw_take;

  assign wr_addr = reg_addr_t'(req_i.awaddr);
  assign slot_ok = (wr_addr.upper == '0) &&
                   (wr_addr.slot < SLOT_IDX_W'(NUM_SLOTS));
  assign is_tdfd = (wr_addr.offset == OFS_TDFD);
  assign is_isr  = (wr_addr.offset == OFS_ISR);
  // only TDFD and ISR are writable
  assign addr_ok = slot_ok && (is_tdfd || is_isr);

  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slot_hit[i]           = aw_take && addr_ok && (wr_addr.slot == SLOT_IDX_W'(i));
      slot_wr_o[i].push     = slot_hit[i] && is_tdfd;
      slot_wr_o[i].tc_clear = slot_hit[i] && is_isr;
      slot_wr_o[i].data     = req_i.wdata;
    end
  end

  // ----------------------------------------------------------
  // write response
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_q <= 1'b0;
    end else if (aw_take) begin
      bvalid_q <= 1'b1;
    end else if (req_i.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_take) begin
      bresp_q <= addr_ok ? RESP_OKAY : RESP_DECERR;
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;

  // a single write never reaches two slots
  a_one_slot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(slot_hit));

endmodule

// File: src/fifo_slot.sv
/*
 * fifo slot
 * one transmit and one receive FIFO behind a slot window; keeps the
 * transmit-complete flag and reports raw counts for register readback
 */
module fifo_slot
  import axil_fifo_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  slot_wr_t          wr_i,
  input  logic              rx_pop_i,
  output logic              tx_valid_o,
  output logic [DATA_W-1:0] tx_data_o,
  input  logic              tx_ready_i,
  input  logic              rx_valid_i,
  input  logic [DATA_W-1:0] rx_data_i,
  output logic              rx_ready_o,
  output slot_status_t      status_o
);

  logic [CNT_W-1:0]  tx_count;
  logic [CNT_W-1:0]  rx_count;
  logic              rx_head_valid;
  logic [DATA_W-1:0] rx_head;
  logic              rx_push;
  logic              tx_deq;
  logic              tx_last;
  logic              tc_q;

  // ----------------------------------------------------------
  // transmit side
  // ----------------------------------------------------------

  // writes to a full FIFO fall away inside sync_fifo
  sync_fifo tx_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (wr_i.push),
    .in_data_i   (wr_i.data),
    .in_ready_o  (),
    .out_valid_o (tx_valid_o),
    .out_data_o  (tx_data_o),
    .out_ready_i (tx_ready_i),
    .count_o     (tx_count)
  );

  assign tx_deq = tx_valid_o && tx_ready_i;
  // last word leaves and nothing new arrives behind it
  assign tx_last = tx_deq && (tx_count == CNT_W'(1)) && !wr_i.push;

  // transmit complete, host clear beats a same-cycle set
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tc_q <= 1'b0;
    end else if (wr_i.tc_clear) begin
      tc_q <= 1'b0;
    end else if (tx_last) begin
      tc_q <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // receive side
  // ----------------------------------------------------------

  // ready only on free space, never on a pending pop
  assign rx_ready_o = (rx_count != CNT_W'(FIFO_DEPTH));
  assign rx_push    = rx_valid_i && rx_ready_o;

  sync_fifo rx_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (rx_push),
    .in_data_i   (rx_data_i),
    .in_ready_o  (),
    .out_valid_o (rx_head_valid),
    .out_data_o  (rx_head),
    .out_ready_i (rx_pop_i),
    .count_o     (rx_count)
  );

  // ----------------------------------------------------------
  // status toward the read mux
  // ----------------------------------------------------------
  always_comb begin
    status_o.tc         = tc_q;
    status_o.tx_vacancy = CNT_W'(FIFO_DEPTH) - tx_count;
    status_o.rx_count   = rx_count;
    status_o.rx_valid   = rx_head_valid;
    status_o.rx_head    = rx_head;
  end

endmodule

// File: src/sync_fifo.sv
/*
 * sync fifo
 * circular buffer with valid/ready on both sides and an
 * occupancy count; a push and a pop in one cycle are taken
 * together even when the buffer is full
 */
module sync_fifo
  import axil_fifo_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              in_valid_i,
  input  logic [DATA_W-1:0] in_data_i,
  output logic              in_ready_o,
  output logic              out_valid_o,
  output logic [DATA_W-1:0] out_data_o,
  input  logic              out_ready_i,
  output logic [CNT_W-1:0]  count_o
);

  logic [DATA_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              push;
  logic              pop;

  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem[rd_ptr_q];
  // full is still writable when the head leaves this cycle
  assign in_ready_o  = (count_q != CNT_W'(FIFO_DEPTH)) || out_ready_i;
  assign count_o     = count_q;

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= in_data_i;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    count_q <= CNT_W'(FIFO_DEPTH));

endmodule

// File: verilog.f
src/axil_fifo_pkg.sv
src/sync_fifo.sv
src/axil_write_decoder.sv
src/fifo_slot.sv
src/axil_read_mux.sv
src/axil_fifo_bridge.sv
bench/tb_axil_fifo_bridge.sv
